/* thor_exec_macros.svh */
/*
  sizing constants for the one-lane integer execute path
  THOR_QDEPTH must be a power of two and at least 2
  THOR_BCD_DIGITS is fixed by the 8-bit BCD multiplier ports
*/
`ifndef THOR_EXEC_MACROS_SVH
`define THOR_EXEC_MACROS_SVH

// ==============================
// datapath
// ==============================
`define THOR_DBW 64 // operand and result width

// tag returned with each result
`define THOR_TAGW 4

// ==============================
// queue and multiplier
// ==============================
`define THOR_QDEPTH 4 // dispatch queue entries, power of two

// digits per BCD multiply operand, also the multiplier step count
`define THOR_BCD_DIGITS 2

`endif

/* thor_exec_pkg.sv */
/*
  opcode and function encodings, instruction word views and the queue entry
  unknown op or fn values travel through the entry unchanged
*/
`default_nettype none
`include "thor_exec_macros.svh"

package thor_exec_pkg;

	// ==============================
	// encodings
	// ==============================
	typedef enum logic [7:0] {
		OP_RR    = 8'h02, // reg add/sub, scaled adds
		OP_LOGIC = 8'h03,
		OP_ADDI  = 8'h04,
		OP_SUBI  = 8'h05,
		OP_CMP   = 8'h06,
		OP_CMPI  = 8'h07,
		OP_ANDI  = 8'h08,
		OP_ORI   = 8'h09,
		OP_EORI  = 8'h0A,
		OP_NEG   = 8'h10,
		OP_NOT   = 8'h11,
		OP_MOV   = 8'h12,
		OP_MUX   = 8'h72,
		OP_BCD   = 8'hF6
	} alu_op_e;

	// one flat space, so RR and LOGIC functions never alias
	typedef enum logic [5:0] {
		FN_ADD    = 6'h00,
		FN_SUB    = 6'h01,
		FN_2ADDU  = 6'h02,
		FN_4ADDU  = 6'h03,
		FN_8ADDU  = 6'h04,
		FN_16ADDU = 6'h05,
		FN_AND    = 6'h08,
		FN_ANDC   = 6'h09,
		FN_OR     = 6'h0A,
		FN_ORC    = 6'h0B,
		FN_EOR    = 6'h0C,
		FN_NAND   = 6'h0D,
		FN_NOR    = 6'h0E,
		FN_ENOR   = 6'h0F,
		FN_BCDADD = 6'h10,
		FN_BCDMUL = 6'h12
	} alu_fn_e;

	// ==============================
	// instruction word, two views
	// ==============================
	typedef struct packed {
		alu_op_e     op;  // [31:24]
		alu_fn_e     fn;  // [23:18]
		logic [17:0] rsv;
	} insn_rr_t;

	typedef struct packed {
		alu_op_e     op;
		logic [7:0]  rsv;
		logic [15:0] imm; // sign extended at issue
	} insn_ri_t;

	typedef union packed {
		insn_rr_t r;
		insn_ri_t i;
	} insn_word_u;

	// decoded entry as held in the dispatch queue
	typedef struct packed {
		alu_op_e               op;
		alu_fn_e               fn;
		logic [`THOR_DBW-1:0]  arg_a;
		logic [`THOR_DBW-1:0]  arg_b; // select-1 source for MUX
		logic [`THOR_DBW-1:0]  arg_c; // select-0 source for MUX
		logic [`THOR_DBW-1:0]  arg_i;
		logic [`THOR_TAGW-1:0] tag;
	} exec_entry_t;

	// 4-digit BCD add, carry in zero, carry out dropped
	function automatic logic [15:0] bcd_add4(input logic [15:0] x, input logic [15:0] y);
		logic [4:0] s;
		logic c;
		logic [15:0] o;
		int i;
		c = 1'b0;
		for (i = 0; i < 4; i++)
		begin
			s = {1'b0, x[i*4 +: 4]} + {1'b0, y[i*4 +: 4]} + {4'h0, c};
			c = s > 5'd9; // decimal carry
			if (c)
				s = s + 5'd6; // skip the six unused codes
			o[i*4 +: 4] = s[3:0];
		end
		return o;
	endfunction

endpackage

`default_nettype wire

/* thor_dispatch_if.sv */
/*
  issue to queue to ALU link
  push has no back-pressure, pop only while empty is low
*/
`timescale 1ns/1ps
`default_nettype none

interface thor_dispatch_if;
	import thor_exec_pkg::*;

	// ==============================
	// write side
	// ==============================
	logic        push;       // one-cycle strobe
	exec_entry_t push_entry; // valid with push

	// ==============================
	// read side
	// ==============================
	logic        pop;        // head leaves on the next edge
	exec_entry_t pop_entry;  // head, combinational
	logic        empty;

	// issue stage only writes
	modport issue
	(
		output push,
		output push_entry
	);

	modport queue
	(
		input  push,
		input  push_entry,
		input  pop,
		output pop_entry,
		output empty
	);

	// ALU drains the head
	modport alu
	(
		input  empty,
		input  pop_entry,
		output pop
	);

endinterface

`default_nettype wire

/* thor_issue.sv */
/*
  one decoded entry per insn_valid, pushed on the following cycle
  op/fn come from the register view, imm from the immediate view
  unknown opcodes are not filtered here
*/
`timescale 1ns/1ps
`default_nettype none
`include "thor_exec_macros.svh"

module thor_issue
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       insn_valid,
	input  thor_exec_pkg::insn_word_u  insn,
	input  logic [`THOR_DBW-1:0]       opa,
	input  logic [`THOR_DBW-1:0]       opb,
	input  logic [`THOR_DBW-1:0]       opc,
	input  logic [`THOR_TAGW-1:0]      tag,
	thor_dispatch_if.issue             dq
);
	import thor_exec_pkg::*;

	logic                 push_q;  // strobe into the queue
	exec_entry_t          entry_q; // decoded entry, no reset
	logic [`THOR_DBW-1:0] imm_ext;

	// ==============================
	// immediate
	// ==============================
	// 16-bit field, sign bit copied up to the data width
	assign imm_ext = {{(`THOR_DBW-16){insn.i.imm[15]}}, insn.i.imm};

	// ==============================
	// entry register
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			push_q <= 1'b0;
		end
		else
		begin
			push_q <= insn_valid; // one cycle behind the strobe
		end
	end

	// payload only moves on a strobe
	always_ff @(posedge clk)
	begin
		if (insn_valid)
		begin
			entry_q.op    <= insn.r.op;   // unknown codes kept as-is
			entry_q.fn    <= insn.r.fn;   // ignored by immediate ops
			entry_q.arg_a <= opa;
			entry_q.arg_b <= opb;         // MUX select-1 source
			entry_q.arg_c <= opc;         // MUX select-0 source
			entry_q.arg_i <= imm_ext;
			entry_q.tag   <= tag;
		end
	end

	// to the queue
	assign dq.push       = push_q;
	assign dq.push_entry = entry_q;

endmodule

`default_nettype wire

/* thor_dispatch_queue.sv */
/*
  circular FIFO of decoded entries, depth THOR_QDEPTH (power of two)
  push onto a full queue without a pop is dropped, overflow pulses same cycle
  head is shown combinationally
*/
`timescale 1ns/1ps
`default_nettype none
`include "thor_exec_macros.svh"

module thor_dispatch_queue
(
	input  logic           clk,
	input  logic           reset,
	thor_dispatch_if.queue dq,
	output logic           overflow
);
	import thor_exec_pkg::*;

	localparam int AW = $clog2(`THOR_QDEPTH);
	localparam logic [AW:0] DEPTH = `THOR_QDEPTH;

	exec_entry_t   mem [`THOR_QDEPTH]; // storage, no reset
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [AW:0]   count;              // one extra bit for full
	logic          full;
	logic          do_push;
	logic          do_pop;

	// ==============================
	// flags
	// ==============================
	assign full     = count == DEPTH;
	assign dq.empty = count == '0;
	assign do_pop   = dq.pop && !dq.empty;
	assign do_push  = dq.push && (!full || do_pop); // pop frees the slot
	assign overflow = dq.push && full && !do_pop;   // entry lost

	assign dq.pop_entry = mem[rd_ptr];

	// ==============================
	// pointers and count
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^AW
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= dq.push_entry;
	end

	// ALU side must honour empty
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		dq.pop |-> !dq.empty)
		else $error("pop while queue empty");

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= DEPTH)
		else $error("queue count above depth");

endmodule

`default_nettype wire

/* thor_bcd_mul.sv */
/*
  iterative 2-digit BCD multiply, one multiplier digit per step, msd first
  done pulses THOR_BCD_DIGITS+1 cycles after start, p holds until next start
  inputs assumed valid BCD
*/
`timescale 1ns/1ps
`default_nettype none
`include "thor_exec_macros.svh"

module thor_bcd_mul
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic [7:0]  a,
	input  logic [7:0]  b,
	output logic        done,
	output logic [15:0] p
);
	import thor_exec_pkg::*;

	localparam int CW = $clog2(`THOR_BCD_DIGITS + 1);
	localparam logic [CW-1:0] STEPS = `THOR_BCD_DIGITS;

	logic [CW-1:0] cnt;  // steps left
	logic [7:0]    a_q;  // multiplicand
	logic [7:0]    b_q;  // multiplier, shifted left a digit per step
	logic [15:0]   acc;
	logic [15:0]   part; // a times current digit

	// repeated BCD add of x, d times
	function automatic logic [15:0] bcd_times(input logic [7:0] x, input logic [3:0] d);
		logic [15:0] m;
		int i;
		m = '0;
		for (i = 0; i < 9; i++)
		begin
			if (i < d)
				m = bcd_add4(m, {8'h00, x});
		end
		return m;
	endfunction

	assign part = bcd_times(a_q, b_q[7:4]);
	assign p    = acc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cnt  <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
				cnt <= STEPS;
			else if (cnt != '0)
			begin
				cnt  <= cnt - 1'b1;
				done <= cnt == CW'(1); // last digit
			end
		end
	end

	// acc = acc*10 + a*digit
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			a_q <= a;
			b_q <= b;
			acc <= '0;
		end
		else if (cnt != '0)
		begin
			acc <= bcd_add4({acc[11:0], 4'h0}, part);
			b_q <= {b_q[3:0], 4'h0};
		end
	end

endmodule

`default_nettype wire

/* thor_alu.sv */
/*
  pops one entry when idle and registers result and tag a cycle later
  BCDMUL holds the ALU busy until the multiplier reports done
  unknown op gives the DEAD marker and unknown fn in a known op gives zero
*/
`timescale 1ns/1ps
`default_nettype none
`include "thor_exec_macros.svh"

module thor_alu
(
	input  logic                  clk,
	input  logic                  reset,
	thor_dispatch_if.alu          dq,
	output logic                  res_valid,
	output logic [`THOR_DBW-1:0]  res,
	output logic [`THOR_TAGW-1:0] res_tag
);
	import thor_exec_pkg::*;

	exec_entry_t           e;       // head of queue
	logic [`THOR_DBW-1:0]  o;       // single-cycle result
	logic [7:0]            bcd_sum;
	logic                  busy;    // multiply in flight
	logic                  is_mul;
	logic                  mul_start;
	logic                  mul_done;
	logic [15:0]           mul_p;
	logic [`THOR_TAGW-1:0] mul_tag; // tag parked during multiply

	assign e         = dq.pop_entry;
	assign dq.pop    = !dq.empty && !busy;
	assign is_mul    = e.op == OP_BCD && e.fn == FN_BCDMUL;
	assign mul_start = dq.pop && is_mul;

	// two digits from each low byte with the carry dropped
	assign bcd_sum = 8'(bcd_add4({8'h00, e.arg_a[7:0]}, {8'h00, e.arg_b[7:0]}));

	thor_bcd_mul u_bcd_mul
	(
		.clk   (clk),
		.reset (reset),
		.start (mul_start),
		.a     (e.arg_a[7:0]),
		.b     (e.arg_b[7:0]),
		.done  (mul_done),
		.p     (mul_p)
	);

	// ==============================
	// operation table
	// ==============================
	always_comb
	begin
		o = '0;
		case (e.op)
			OP_RR:
				case (e.fn)
					FN_ADD:    o = e.arg_a + e.arg_b;
					FN_SUB:    o = e.arg_a - e.arg_b;
					FN_2ADDU:  o = (e.arg_a << 1) + e.arg_b; // scaled adds
					FN_4ADDU:  o = (e.arg_a << 2) + e.arg_b;
					FN_8ADDU:  o = (e.arg_a << 3) + e.arg_b;
					FN_16ADDU: o = (e.arg_a << 4) + e.arg_b;
					default:   o = '0;
				endcase
			OP_LOGIC:
				case (e.fn)
					FN_AND:  o = e.arg_a & e.arg_b;
					FN_ANDC: o = e.arg_a & ~e.arg_b;
					FN_OR:   o = e.arg_a | e.arg_b;
					FN_ORC:  o = e.arg_a | ~e.arg_b;
					FN_EOR:  o = e.arg_a ^ e.arg_b;
					FN_NAND: o = ~(e.arg_a & e.arg_b);
					FN_NOR:  o = ~(e.arg_a | e.arg_b);
					FN_ENOR: o = ~(e.arg_a ^ e.arg_b);
					default: o = '0;
				endcase
			OP_ADDI: o = e.arg_a + e.arg_i;
			OP_SUBI: o = e.arg_a - e.arg_i;
			OP_ANDI: o = e.arg_a & e.arg_i;
			OP_ORI:  o = e.arg_a | e.arg_i;
			OP_EORI: o = e.arg_a ^ e.arg_i;
			OP_CMP:
			begin
				o[0] = e.arg_a == e.arg_b;                   // eq
				o[1] = $signed(e.arg_a) < $signed(e.arg_b);  // signed lt
				o[2] = e.arg_a < e.arg_b;                    // unsigned lt
			end
			OP_CMPI:
			begin
				o[0] = e.arg_a == e.arg_i;
				o[1] = $signed(e.arg_a) < $signed(e.arg_i);
				o[2] = e.arg_a < e.arg_i;
			end
			OP_NEG: o = -e.arg_a;
			OP_NOT: o = ~e.arg_a;
			OP_MOV: o = e.arg_a;
			OP_MUX: o = (e.arg_a & e.arg_b) | (~e.arg_a & e.arg_c); // a selects per bit
			OP_BCD:
				case (e.fn)
					FN_BCDADD: o = {{(`THOR_DBW-8){1'b0}}, bcd_sum};
					default:   o = '0; // BCDMUL product comes from the multiplier
				endcase
			default: o = {(`THOR_DBW/16){16'hDEAD}};
		endcase
	end

	// ==============================
	// result register
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			res_valid <= 1'b0;
			busy      <= 1'b0;
		end
		else
		begin
			res_valid <= (dq.pop && !is_mul) || mul_done;
			if (mul_start)
				busy <= 1'b1;
			else if (mul_done)
				busy <= 1'b0; // pops resume next cycle
		end
	end

	always_ff @(posedge clk)
	begin
		if (mul_start)
			mul_tag <= e.tag;
		if (mul_done)
		begin
			res     <= {{(`THOR_DBW-16){1'b0}}, mul_p};
			res_tag <= mul_tag;
		end
		else if (dq.pop && !is_mul)
		begin
			res     <= o;
			res_tag <= e.tag;
		end
	end

	// no back-to-back results while the multiplier owns the ALU
	a_mul_quiet: assert property (@(posedge clk) disable iff (reset)
		busy |-> !(res_valid && $past(res_valid)))
		else $error("result strobe repeated during multiply");

endmodule

`default_nettype wire

/* thor_exec_top.sv */
/*
  one-lane execute path, issue -> dispatch queue -> ALU
  no back-pressure, watch overflow
  single-cycle op into an idle pipe returns 3 cycles after insn_valid
*/
`timescale 1ns/1ps
`default_nettype none
`include "thor_exec_macros.svh"

module thor_exec_top
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  insn_valid, // strobe
	input  logic [31:0]           insn,
	input  logic [`THOR_DBW-1:0]  opa,
	input  logic [`THOR_DBW-1:0]  opb,
	input  logic [`THOR_DBW-1:0]  opc,
	input  logic [`THOR_TAGW-1:0] tag,
	output logic                  res_valid,  // strobe
	output logic [`THOR_DBW-1:0]  res,
	output logic [`THOR_TAGW-1:0] res_tag,
	output logic                  overflow    // dropped instruction
);

	thor_dispatch_if dq_if ();

	// ==============================
	// pipeline
	// ==============================
	thor_issue u_issue
	(
		.clk        (clk),
		.reset      (reset),
		.insn_valid (insn_valid),
		.insn       (insn),
		.opa        (opa),
		.opb        (opb),
		.opc        (opc),
		.tag        (tag),
		.dq         (dq_if.issue)
	);

	thor_dispatch_queue u_queue
	(
		.clk      (clk),
		.reset    (reset),
		.dq       (dq_if.queue),
		.overflow (overflow)
	);

	thor_alu u_alu
	(
		.clk       (clk),
		.reset     (reset),
		.dq        (dq_if.alu),
		.res_valid (res_valid),
		.res       (res),
		.res_tag   (res_tag)
	);

endmodule

`default_nettype wire

/* tb_thor_exec.sv */
/*
  testbench for the one-lane execute path, DUT instance dut0
  expects THOR_DBW of 64 and valid BCD digits in BCD operands
  burst drop prediction assumes an idle pipeline at burst start
*/
`timescale 1ns/1ps
`default_nettype none
`include "thor_exec_macros.svh"

module tb_thor_exec;
	import thor_exec_pkg::*;

	localparam int N_DIRECTED = 40;  // upper bound on directed items
	localparam int N_BCD      = 40;  // pairs, each sent as add and multiply
	localparam int N_RAND     = 300;
	localparam int N_BURST    = 12;
	localparam int N_ISSUED   = N_DIRECTED + 2 * N_BCD + N_RAND + N_BURST;
	localparam int TIMEOUT_NS = N_ISSUED * (`THOR_BCD_DIGITS + 4) * 10 + 2000;

	localparam logic [`THOR_DBW-1:0] VA   = 64'h0123_4567_89AB_CDEF;
	localparam logic [`THOR_DBW-1:0] VB   = 64'hFEDC_BA98_7654_3210;
	localparam logic [`THOR_DBW-1:0] VC   = 64'h5555_AAAA_F0F0_0F0F;
	localparam logic [`THOR_DBW-1:0] MAXS = 64'h7FFF_FFFF_FFFF_FFFF;
	localparam logic [`THOR_DBW-1:0] MINS = 64'h8000_0000_0000_0000;
	localparam logic [`THOR_DBW-1:0] ONES = '1;

	logic                  clk;
	logic                  reset;
	logic                  insn_valid;
	logic [31:0]           insn;
	logic [`THOR_DBW-1:0]  opa;
	logic [`THOR_DBW-1:0]  opb;
	logic [`THOR_DBW-1:0]  opc;
	logic [`THOR_TAGW-1:0] tag;
	logic                  res_valid;
	logic [`THOR_DBW-1:0]  res;
	logic [`THOR_TAGW-1:0] res_tag;
	logic                  overflow;

	// scoreboard, one slot per accepted instruction
	logic [`THOR_DBW-1:0]  exp_val [$];
	logic [`THOR_TAGW-1:0] exp_tag [$];
	int                    exp_cyc [$];  // cycle of insn_valid
	bit                    exp_lat [$];  // check the 3-cycle latency
	string                 exp_name [$];

	integer                seed = 86158;
	int                    cyc = 0;       // rising edges seen
	int                    err_mismatch = 0;
	int                    err_other = 0;
	int                    n_checked = 0;
	int                    ovf_seen = 0;
	int                    ovf_pred = 0;
	bit                    burst_on = 1'b0;
	bit                    kept [N_BURST]; // predicted burst survivors
	logic [`THOR_TAGW-1:0] tag_ctr = '0;

	thor_exec_top dut0
	(
		.clk        (clk),
		.reset      (reset),
		.insn_valid (insn_valid),
		.insn       (insn),
		.opa        (opa),
		.opb        (opb),
		.opc        (opc),
		.tag        (tag),
		.res_valid  (res_valid),
		.res        (res),
		.res_tag    (res_tag),
		.overflow   (overflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// ==============================
	// reference model
	// ==============================
	function automatic int bcd_to_int(input logic [7:0] x);
		return int'(x[7:4]) * 10 + int'(x[3:0]);
	endfunction

	function automatic logic [15:0] int_to_bcd(input int v);
		logic [15:0] d;
		int k;
		for (k = 0; k < 4; k++)
		begin
			d[k*4 +: 4] = 4'(v % 10); // least significant digit first
			v = v / 10;
		end
		return d;
	endfunction

	function automatic logic [`THOR_DBW-1:0] ref_exec(input logic [7:0] op,
		input logic [5:0] fn, input logic [`THOR_DBW-1:0] a,
		input logic [`THOR_DBW-1:0] b, input logic [`THOR_DBW-1:0] c,
		input logic [15:0] imm);
		logic [`THOR_DBW-1:0] i;
		logic [`THOR_DBW-1:0] r;
		logic [15:0] d;
		i = {{(`THOR_DBW-16){imm[15]}}, imm}; // sign-extended immediate
		r = '0;
		case (op)
			OP_RR:
				case (fn)
					FN_ADD:    r = a + b;
					FN_SUB:    r = a - b;
					FN_2ADDU:  r = a * 2 + b;
					FN_4ADDU:  r = a * 4 + b;
					FN_8ADDU:  r = a * 8 + b;
					FN_16ADDU: r = a * 16 + b;
					default:   r = '0;
				endcase
			OP_LOGIC:
				case (fn)
					FN_AND:  r = a & b;
					FN_ANDC: r = a & ~b;
					FN_OR:   r = a | b;
					FN_ORC:  r = a | ~b;
					FN_EOR:  r = a ^ b;
					FN_NAND: r = ~(a & b);
					FN_NOR:  r = ~(a | b);
					FN_ENOR: r = ~(a ^ b);
					default: r = '0;
				endcase
			OP_ADDI: r = a + i;
			OP_SUBI: r = a - i;
			OP_ANDI: r = a & i;
			OP_ORI:  r = a | i;
			OP_EORI: r = a ^ i;
			OP_CMP, OP_CMPI:
			begin
				if (op == OP_CMPI)
					b = i; // same bit layout for both forms
				r[0] = a == b;
				r[1] = $signed(a) < $signed(b);
				r[2] = a < b;
			end
			OP_NEG: r = 0 - a;
			OP_NOT: r = ~a;
			OP_MOV: r = a;
			OP_MUX: r = (b & a) | (c & ~a); // a=1 picks b
			OP_BCD:
				case (fn)
					FN_BCDADD:
					begin
						d = int_to_bcd((bcd_to_int(a[7:0]) + bcd_to_int(b[7:0])) % 100);
						r = {{(`THOR_DBW-8){1'b0}}, d[7:0]};
					end
					FN_BCDMUL:
					begin
						d = int_to_bcd(bcd_to_int(a[7:0]) * bcd_to_int(b[7:0]));
						r = {{(`THOR_DBW-16){1'b0}}, d};
					end
					default: r = '0;
				endcase
			default: r = 64'hDEAD_DEAD_DEAD_DEAD;
		endcase
		return r;
	endfunction

	function automatic logic [3:0] rand_digit();
		return 4'($unsigned($random(seed)) % 10);
	endfunction

	// ==============================
	// stimulus tasks
	// ==============================
	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			insn_valid = 1'b0;
		end
	endtask

	// one instruction, one cycle; keep=0 means a predicted drop
	task automatic send(input logic [7:0] op, input logic [5:0] fn,
		input logic [`THOR_DBW-1:0] a, input logic [`THOR_DBW-1:0] b,
		input logic [`THOR_DBW-1:0] c, input logic [15:0] imm,
		input bit keep, input bit lat, input string name);
		@(posedge clk);
		#1;
		insn_valid = 1'b1;
		insn       = {op, fn, 2'b00, imm}; // fits both word views
		opa        = a;
		opb        = b;
		opc        = c;
		tag        = tag_ctr;
		if (keep)
		begin
			exp_val.push_back(ref_exec(op, fn, a, b, c, imm));
			exp_tag.push_back(tag_ctr);
			exp_cyc.push_back(cyc);
			exp_lat.push_back(lat);
			exp_name.push_back(name);
		end
		tag_ctr = tag_ctr + 1'b1;
	endtask

	// wait until every accepted instruction has returned
	task automatic drain();
		idle(1);
		while (exp_val.size() != 0)
			@(posedge clk);
		idle(1);
	endtask

	task automatic directed(input logic [7:0] op, input logic [5:0] fn,
		input logic [`THOR_DBW-1:0] a, input logic [`THOR_DBW-1:0] b,
		input logic [`THOR_DBW-1:0] c, input logic [15:0] imm, input string name);
		send(op, fn, a, b, c, imm, 1'b1, 1'b1, name);
		drain(); // idle pipe for the next latency check
	endtask

	// multiply holds the ALU for DIGITS+2 cycles, gap keeps the queue short
	task automatic send_spaced(input logic [7:0] op, input logic [5:0] fn,
		input logic [`THOR_DBW-1:0] a, input logic [`THOR_DBW-1:0] b,
		input logic [`THOR_DBW-1:0] c, input logic [15:0] imm, input string name);
		send(op, fn, a, b, c, imm, 1'b1, 1'b0, name);
		if (op == OP_BCD && fn == FN_BCDMUL)
			idle(`THOR_BCD_DIGITS + 2);
	endtask

	task automatic random_mix(input int n);
		int k;
		int sel;
		logic [7:0] op;
		logic [5:0] fn;
		logic [`THOR_DBW-1:0] a;
		logic [`THOR_DBW-1:0] b;
		logic [`THOR_DBW-1:0] c;
		logic [15:0] imm;
		for (k = 0; k < n; k++)
		begin
			a   = {$random(seed), $random(seed)};
			b   = {$random(seed), $random(seed)};
			c   = {$random(seed), $random(seed)};
			imm = 16'($random(seed));
			fn  = FN_ADD;
			sel = int'($unsigned($random(seed)) % 11);
			case (sel)
				0:       op = OP_RR;
				1:       op = OP_LOGIC;
				2:       op = OP_ADDI;
				3:       op = (imm[0]) ? OP_SUBI : OP_ANDI;
				4:       op = (imm[1]) ? OP_ORI : OP_EORI;
				5:       op = (imm[2]) ? OP_CMP : OP_CMPI;
				6:       op = (imm[3]) ? OP_NEG : ((imm[4]) ? OP_NOT : OP_MOV);
				7:       op = OP_MUX;
				default: op = OP_BCD; // add or multiply, see below
			endcase
			if (op == OP_RR)
				fn = 6'($unsigned($random(seed)) % 6);
			if (op == OP_LOGIC)
				fn = 6'(8 + $unsigned($random(seed)) % 8);
			if (op == OP_BCD)
			begin
				fn        = (sel == 8) ? FN_BCDADD : FN_BCDMUL;
				a[7:0]    = {rand_digit(), rand_digit()};
				b[7:0]    = {rand_digit(), rand_digit()};
			end
			send_spaced(op, fn, a, b, c, imm, $sformatf("random #%0d", k));
		end
	endtask

	// queue model: push per cycle, pop when head present and ALU free
	task automatic predict_burst(input int n);
		int t;
		int cnt;
		int free_at;
		bit pops;
		cnt      = 0;
		free_at  = 0;
		ovf_pred = 0;
		for (t = 0; t < n; t++)
		begin
			pops    = cnt > 0 && t >= free_at;
			kept[t] = cnt < `THOR_QDEPTH || pops; // pop frees the slot
			if (pops)
				free_at = t + `THOR_BCD_DIGITS + 2;
			if (!kept[t])
				ovf_pred++;
			cnt = cnt + (kept[t] ? 1 : 0) - (pops ? 1 : 0);
		end
	endtask

	task automatic burst_test();
		int k;
		logic [`THOR_DBW-1:0] a;
		logic [`THOR_DBW-1:0] b;
		drain();
		predict_burst(N_BURST);
		ovf_seen = 0;
		burst_on = 1'b1;
		for (k = 0; k < N_BURST; k++)
		begin
			a = {56'd0, rand_digit(), rand_digit()};
			b = {56'd0, rand_digit(), rand_digit()};
			send(OP_BCD, FN_BCDMUL, a, b, '0, 16'h0, kept[k], 1'b0,
				$sformatf("burst #%0d", k));
		end
		drain();
		burst_on = 1'b0;
		assert (ovf_seen == ovf_pred)
		else
		begin
			err_mismatch++;
			$display("MISMATCH burst overflow count: expected %0d actual %0d",
				ovf_pred, ovf_seen);
		end
	endtask

	// ==============================
	// compare process
	// ==============================
	always @(posedge clk)
	begin : compare
		logic [`THOR_DBW-1:0]  e_val;
		logic [`THOR_TAGW-1:0] e_tag;
		int                    e_cyc;
		bit                    e_lat;
		string                 e_name;
		if (reset === 1'b1 && cyc > 0)
			assert (res_valid === 1'b0 && overflow === 1'b0)
			else
			begin
				err_other++;
				$display("ERROR: result or overflow strobe active during reset");
			end
		if (res_valid === 1'b1)
		begin
			assert (exp_val.size() != 0)
			else
			begin
				err_other++;
				$display("ERROR: result strobe with no instruction outstanding");
			end
			if (exp_val.size() != 0)
			begin
				e_val  = exp_val.pop_front();
				e_tag  = exp_tag.pop_front();
				e_cyc  = exp_cyc.pop_front();
				e_lat  = exp_lat.pop_front();
				e_name = exp_name.pop_front();
				n_checked++;
				assert (res === e_val)
				else
				begin
					err_mismatch++;
					$display("MISMATCH %s: expected %h actual %h", e_name, e_val, res);
				end
				assert (res_tag === e_tag)
				else
				begin
					err_mismatch++;
					$display("MISMATCH %s tag: expected %0d actual %0d", e_name, e_tag, res_tag);
				end
				if (e_lat)
					assert (cyc - e_cyc == 3)
					else
					begin
						err_mismatch++;
						$display("MISMATCH %s latency: expected 3 actual %0d", e_name, cyc - e_cyc);
					end
			end
		end
		if (overflow === 1'b1)
		begin
			assert (burst_on)
			else
			begin
				err_other++;
				$display("ERROR: overflow pulsed while the queue should have room");
			end
			ovf_seen++;
		end
		cyc <= cyc + 1;
	end

	initial
	begin : watchdog
		#(TIMEOUT_NS);
		$display("ERROR: timeout, results stopped arriving before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

	// ==============================
	// test sequence
	// ==============================
	initial
	begin : stimulus
		int f;
		int k;
		logic [7:0] x;
		logic [7:0] y;
		reset      = 1'b1;
		insn_valid = 1'b0;
		insn       = '0;
		opa        = '0;
		opb        = '0;
		opc        = '0;
		tag        = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		idle(4); // strobes must stay quiet here

		// single-cycle ops, exact latency
		for (f = 0; f < 6; f++)
			directed(OP_RR, 6'(f), VA, VB, VC, 16'h0, $sformatf("rr fn %0d", f));
		for (f = 8; f < 16; f++)
			directed(OP_LOGIC, 6'(f), VA, VB, VC, 16'h0, $sformatf("logic fn %0d", f));
		directed(OP_ADDI, 6'h0, VA, VB, VC, 16'hFFF0, "addi negative");
		directed(OP_SUBI, 6'h0, VA, VB, VC, 16'h8000, "subi most negative");
		directed(OP_ANDI, 6'h0, VA, VB, VC, 16'hFF00, "andi negative");
		directed(OP_ORI, 6'h0, VA, VB, VC, 16'h8001, "ori negative");
		directed(OP_EORI, 6'h0, VA, VB, VC, 16'hFFFF, "eori minus one");
		directed(OP_NEG, 6'h0, VA, VB, VC, 16'h0, "neg");
		directed(OP_NOT, 6'h0, VA, VB, VC, 16'h0, "not");
		directed(OP_MOV, 6'h0, VA, VB, VC, 16'h0, "mov");
		directed(OP_MUX, 6'h0, VC, VA, VB, 16'h0, "mux");
		directed(OP_CMP, 6'h0, '0, '0, VC, 16'h0, "cmp zero zero");
		directed(OP_CMP, 6'h0, MINS, MAXS, VC, 16'h0, "cmp min max");
		directed(OP_CMP, 6'h0, MAXS, MINS, VC, 16'h0, "cmp max min");
		directed(OP_CMP, 6'h0, ONES, '0, VC, 16'h0, "cmp ones zero");
		directed(OP_CMP, 6'h0, '0, ONES, VC, 16'h0, "cmp zero ones");
		directed(OP_CMP, 6'h0, 64'd1, 64'd2, VC, 16'h0, "cmp one two");
		directed(OP_CMPI, 6'h0, ONES, VB, VC, 16'hFFFF, "cmpi minus one");
		directed(OP_CMPI, 6'h0, '0, VB, VC, 16'h8000, "cmpi zero min");
		directed(OP_CMPI, 6'h0, MINS, VB, VC, 16'h0001, "cmpi min one");

		// unknown encodings
		directed(8'h55, 6'h0, VA, VB, VC, 16'h0, "unknown op");
		directed(OP_RR, 6'h3F, VA, VB, VC, 16'h0, "rr unknown fn");
		directed(OP_LOGIC, 6'h00, VA, VB, VC, 16'h0, "logic unknown fn");
		directed(OP_BCD, 6'h11, VA, VB, VC, 16'h0, "bcd unknown fn");

		// BCD pairs, first one is 99 x 99
		for (k = 0; k < N_BCD; k++)
		begin
			x = (k == 0) ? 8'h99 : {rand_digit(), rand_digit()};
			y = (k == 0) ? 8'h99 : {rand_digit(), rand_digit()};
			send_spaced(OP_BCD, FN_BCDADD, {VA[63:8], x}, {VB[63:8], y}, VC, 16'h0,
				$sformatf("bcdadd %h+%h", x, y));
			send_spaced(OP_BCD, FN_BCDMUL, {VB[63:8], x}, {VA[63:8], y}, VC, 16'h0,
				$sformatf("bcdmul %h*%h", x, y));
		end
		drain();

		random_mix(N_RAND);
		drain();

		burst_test();

		$display("errors: %0d mismatches, %0d other, %0d results checked",
			err_mismatch, err_other, n_checked);
		if (err_mismatch == 0 && err_other == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* thor_exec.f */
+incdir+.
thor_exec_pkg.sv
thor_dispatch_if.sv
thor_issue.sv
thor_dispatch_queue.sv
thor_bcd_mul.sv
thor_alu.sv
thor_exec_top.sv
tb_thor_exec.sv
